/* src.f */
source/rv_pkg.sv
source/alu.sv
source/register_file.sv
source/instr_decoder.sv
source/cpu_pipeline.sv
source/cpu_ctrl_regs.sv
source/cpu_top.sv
tb/instr_mem_model.sv
tb/cpu_tb.sv

/* Bender.yml */
package:
  name: rv32i_core

sources:
  - source/rv_pkg.sv
  - source/alu.sv
  - source/register_file.sv
  - source/instr_decoder.sv
  - source/cpu_pipeline.sv
  - source/cpu_ctrl_regs.sv
  - source/cpu_top.sv
  - target: test
    files:
      - tb/instr_mem_model.sv
      - tb/cpu_tb.sv

/* tb/cpu_tb.sv */
// Testbench for cpu_top: runs random programs over APB and checks them against an ISA model
`timescale 1ns/1ns
`default_nettype none

module cpu_tb;
    import rv_pkg::*;

    localparam int          CLK_PERIOD = 100;
    localparam int          DRIVE_SKEW = 10;
    localparam logic [31:0] SEED       = 32'he006;
    // Three programs of up to 64 words at 4 cycles worst case, plus APB polling
    // and 32-register readback per program, rounded up with a wide margin
    localparam int unsigned MAX_CYCLES = 20000;

    logic        clk;
    logic        reset_n;
    imem_req_t   imem_req;
    imem_rsp_t   imem_rsp;
    apb_req_t    apb_req;
    apb_rsp_t    apb_rsp;
    xlen_t       model_regs [NREGS];
    int unsigned cycles = 0;

    cpu_top DUT (
        .clk      (clk),
        .reset_n  (reset_n),
        .imem_req (imem_req),
        .imem_rsp (imem_rsp),
        .apb_req  (apb_req),
        .apb_rsp  (apb_rsp)
    );

    instr_mem_model u_imem (
        .clk      (clk),
        .reset_n  (reset_n),
        .imem_req (imem_req),
        .imem_rsp (imem_rsp)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles > MAX_CYCLES) begin
            $display("Timeout: the run did not finish within %0d cycles", MAX_CYCLES);
            $display("Regression failed");
            $fatal(1);
        end
    end

    // ------------------------------------------------------------
    // Checking and APB access
    // ------------------------------------------------------------
    task automatic check_value(input string name, input xlen_t actual, input xlen_t expected);
        assert (actual === expected) else begin
            $display("ERR %s expected 0x%08h actual 0x%08h", name, expected, actual);
            $display("Regression failed");
            $fatal(1);
        end
    endtask

    // Starts and ends DRIVE_SKEW after a rising edge
    task automatic apb_transfer(input logic write, input apb_addr_t addr, input xlen_t wdata,
                                output xlen_t rdata, output logic slverr);
        apb_req.psel    = 1'b1;
        apb_req.penable = 1'b0;
        apb_req.pwrite  = write;
        apb_req.paddr   = addr;
        apb_req.pwdata  = wdata;
        @(posedge clk);
        #DRIVE_SKEW;
        apb_req.penable = 1'b1;
        // Mid access cycle, away from both edges
        #(CLK_PERIOD / 2 - DRIVE_SKEW);
        rdata  = apb_rsp.prdata;
        slverr = apb_rsp.pslverr;
        @(posedge clk);
        #DRIVE_SKEW;
        apb_req = '0;
    endtask

    task automatic write_reg(input apb_addr_t addr, input xlen_t data);
        xlen_t rdata;
        logic  err;
        apb_transfer(1'b1, addr, data, rdata, err);
        check_value("pslverr", {31'b0, err}, '0);
    endtask

    task automatic read_reg(input apb_addr_t addr, output xlen_t data);
        logic err;
        apb_transfer(1'b0, addr, '0, data, err);
        check_value("pslverr", {31'b0, err}, '0);
    endtask

    task automatic access_must_fail(input logic write, input apb_addr_t addr);
        xlen_t rdata;
        logic  err;
        apb_transfer(write, addr, 32'hdead_beef, rdata, err);
        check_value("pslverr", {31'b0, err}, 32'd1);
    endtask

    // ------------------------------------------------------------
    // Program generation
    // ------------------------------------------------------------
    // Kinds 0 to 7 follow funct3, 8 is SUB and 9 is SRA
    function automatic instr_t encode_r(input int kind, input reg_idx_t rd,
                                        input reg_idx_t rs1, input reg_idx_t rs2);
        logic [2:0] f3;
        logic [6:0] f7;
        f3 = (kind == 8) ? 3'd0 : (kind == 9) ? 3'd5 : kind[2:0];
        f7 = (kind >= 8) ? 7'h20 : 7'h00;
        return {f7, rs2, rs1, f3, rd, OPC_OP};
    endfunction

    function automatic instr_t encode_addi(input reg_idx_t rd, input reg_idx_t rs1,
                                           input logic [11:0] imm);
        return {imm, rs1, 3'b000, rd, OPC_OP_IMM};
    endfunction

    function automatic instr_t encode_beq(input reg_idx_t rs1, input reg_idx_t rs2,
                                          input logic [12:0] off);
        return {off[12], off[10:5], rs2, rs1, 3'b000, off[4:1], off[11], OPC_BRANCH};
    endfunction

    // Few registers, so most instructions depend on recent results
    function automatic reg_idx_t pick_reg();
        return reg_idx_t'($urandom_range(7, 0));
    endfunction

    task automatic build_program(input addr_t boot, input int unsigned words,
                                 input logic with_branches);
        instr_t   word;
        reg_idx_t rs1;
        reg_idx_t rs2;
        u_imem.base   = boot;
        u_imem.length = words;
        for (int i = 0; i < words; i++) begin
            rs1 = pick_reg();
            rs2 = pick_reg();
            if (i == 0) begin
                // Writes x0, which has to stay zero
                word = encode_addi(5'd0, rs1, 12'($urandom_range(4095, 0)));
            end else if (with_branches && $urandom_range(3, 0) == 0) begin
                // Same register on both sides gives a taken branch
                if ($urandom_range(1, 0) == 1) begin
                    rs2 = rs1;
                end
                word = encode_beq(rs1, rs2, 13'(4 * $urandom_range(4, 2)));
            end else if ($urandom_range(2, 0) != 0) begin
                word = encode_r(int'($urandom_range(9, 0)), pick_reg(), rs1, rs2);
            end else begin
                word = encode_addi(pick_reg(), rs1, 12'($urandom_range(4095, 0)));
            end
            u_imem.prog[i] = word;
        end
    endtask

    // ------------------------------------------------------------
    // ISA reference model
    // ------------------------------------------------------------
    // Runs from boot until the PC leaves the program, returns the executed count
    function automatic int unsigned interpret_program(input addr_t boot);
        addr_t       pc;
        addr_t       offset;
        instr_t      word;
        xlen_t       a;
        xlen_t       b;
        xlen_t       res;
        logic [4:0]  sh;
        int unsigned executed;
        executed = 0;
        pc       = boot;
        offset   = pc - u_imem.base;
        while (offset < 4 * u_imem.length) begin
            word = u_imem.prog[offset >> 2];
            a    = model_regs[word[19:15]];
            b    = model_regs[word[24:20]];
            sh   = b[4:0];
            res  = '0;
            executed++;
            if (word[6:0] == OPC_BRANCH) begin
                if (a == b) begin
                    pc = pc + {{19{word[31]}}, word[31], word[7], word[30:25],
                               word[11:8], 1'b0};
                end else begin
                    pc = pc + 32'd4;
                end
            end else begin
                pc = pc + 32'd4;
                if (word[6:0] == OPC_OP_IMM) begin
                    res = a + {{20{word[31]}}, word[31:20]};
                end else begin
                    case (word[14:12])
                        3'd0: res = word[30] ? a - b : a + b;
                        3'd1: res = a << sh;
                        3'd2: res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                        3'd3: res = (a < b) ? 32'd1 : 32'd0;
                        3'd4: res = a ^ b;
                        3'd5: begin
                            if (word[30]) begin
                                res = $signed(a) >>> sh;
                            end else begin
                                res = a >> sh;
                            end
                        end
                        3'd6: res = a | b;
                        default: res = a & b;
                    endcase
                end
                if (word[11:7] != 5'd0) begin
                    model_regs[word[11:7]] = res;
                end
            end
            offset = pc - u_imem.base;
        end
        return executed;
    endfunction

    // Start the core, wait for the drain, then compare count and registers
    task automatic run_and_compare(input addr_t boot);
        int unsigned expected;
        xlen_t       value;
        expected = interpret_program(boot);
        write_reg(REG_RETIRED, '0);
        write_reg(REG_BOOT_PC, boot);
        write_reg(REG_CTRL, 32'd1);
        do begin
            read_reg(REG_RETIRED, value);
        end while (value < expected);
        write_reg(REG_CTRL, '0);
        do begin
            read_reg(REG_STATUS, value);
        end while (value[0]);
        read_reg(REG_RETIRED, value);
        check_value("RETIRED", value, expected);
        for (int i = 0; i < NREGS; i++) begin
            read_reg(REG_XREG_BASE + apb_addr_t'(4 * i), value);
            check_value($sformatf("x%0d", i), value, model_regs[i]);
        end
    endtask

    // ------------------------------------------------------------
    // Test sequence
    // ------------------------------------------------------------
    initial begin
        addr_t boot;
        xlen_t value;
        void'($urandom(SEED));
        reset_n = 1'b0;
        apb_req = '0;
        for (int i = 0; i < NREGS; i++) begin
            model_regs[i] = '0;
        end
        for (int i = 0; i < u_imem.LAT_WORDS; i++) begin
            u_imem.latency[i] = 2'($urandom_range(3, 0));
        end
        repeat (4) @(posedge clk);
        #DRIVE_SKEW;
        reset_n = 1'b1;

        // Reset values
        check_value("imem_req.req", {31'b0, imem_req.req}, '0);
        read_reg(REG_CTRL, value);
        check_value("CTRL", value, '0);
        read_reg(REG_STATUS, value);
        check_value("STATUS", value, '0);
        read_reg(REG_RETIRED, value);
        check_value("RETIRED", value, '0);

        // Register access and error responses
        write_reg(REG_BOOT_PC, 32'h0000_a5a4);
        read_reg(REG_BOOT_PC, value);
        check_value("BOOT_PC", value, 32'h0000_a5a4);
        access_must_fail(1'b0, 12'h010);
        access_must_fail(1'b1, REG_STATUS);
        access_must_fail(1'b1, REG_XREG_BASE + 12'h00C);

        // ALU only, then branch mixes from fresh boot addresses
        boot = $urandom & 32'h0003_fffc;
        build_program(boot, 64, 1'b0);
        run_and_compare(boot);
        boot = $urandom & 32'h0003_fffc;
        build_program(boot, 48, 1'b1);
        run_and_compare(boot);
        boot = $urandom & 32'h0003_fffc;
        build_program(boot, 64, 1'b1);
        run_and_compare(boot);

        $display("Regression passed");
        $finish;
    end

endmodule

`default_nettype wire

/* tb/instr_mem_model.sv */
// Instruction memory model for the testbench; answers fetches after a latency taken from a table
`timescale 1ns/1ns
`default_nettype none

module instr_mem_model (
    input  wire                    clk,
    input  wire                    reset_n,
    input  wire rv_pkg::imem_req_t imem_req,
    output rv_pkg::imem_rsp_t      imem_rsp
);
    import rv_pkg::*;

    localparam int PROG_WORDS = 64;
    localparam int LAT_WORDS  = 1024;

    // Program image, filled by the testbench before each run
    instr_t      prog [PROG_WORDS];
    addr_t       base;
    int unsigned length;

    // Fetch latencies of 0 to 3 cycles, used in order
    logic [1:0]  latency [LAT_WORDS];
    int unsigned lat_ptr;
    int          wait_left;

    // Anything outside the loaded program reads as a bubble
    function automatic instr_t word_at(input addr_t addr);
        addr_t offset;
        offset = addr - base;
        if (addr[1:0] != 2'b00 || offset >= 4 * length) begin
            return NOP_INSTR;
        end
        return prog[offset >> 2];
    endfunction

    initial begin
        imem_rsp  = '0;
        lat_ptr   = 0;
        wait_left = -1;
        forever begin
            @(posedge clk);
            #10;
            imem_rsp = '0;
            if (!reset_n || !imem_req.req) begin
                wait_left = -1;
            end else begin
                // New request, draw its latency
                if (wait_left < 0) begin
                    wait_left = int'(latency[lat_ptr % LAT_WORDS]);
                    lat_ptr++;
                end
                if (wait_left == 0) begin
                    imem_rsp.ready = 1'b1;
                    imem_rsp.rdata = word_at(imem_req.addr);
                    wait_left      = -1;
                end else begin
                    wait_left--;
                end
            end
        end
    end

endmodule

`default_nettype wire

/* source/cpu_top.sv */
// Core top level: pipeline, register file and APB control block wired together
`timescale 1ns/1ns
`default_nettype none

module cpu_top (
    input  wire                    clk,
    input  wire                    reset_n,
    output rv_pkg::imem_req_t      imem_req,
    input  wire rv_pkg::imem_rsp_t imem_rsp,
    input  wire rv_pkg::apb_req_t  apb_req,
    output rv_pkg::apb_rsp_t       apb_rsp
);
    import rv_pkg::*;

    logic     run;
    addr_t    boot_pc;
    logic     busy;
    logic     retire;
    logic     wr_en;
    reg_idx_t rs1_idx;
    reg_idx_t rs2_idx;
    reg_idx_t wr_idx;
    reg_idx_t dbg_idx;
    xlen_t    rs1_data;
    xlen_t    rs2_data;
    xlen_t    wr_data;
    xlen_t    dbg_data;

    cpu_pipeline u_pipeline (
        .clk      (clk),
        .reset_n  (reset_n),
        .run      (run),
        .boot_pc  (boot_pc),
        .imem_req (imem_req),
        .imem_rsp (imem_rsp),
        .rs1_idx  (rs1_idx),
        .rs2_idx  (rs2_idx),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data),
        .wr_en    (wr_en),
        .wr_idx   (wr_idx),
        .wr_data  (wr_data),
        .busy     (busy),
        .retire   (retire)
    );

    register_file u_regfile (
        .clk      (clk),
        .reset_n  (reset_n),
        .rs1_idx  (rs1_idx),
        .rs2_idx  (rs2_idx),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data),
        .wr_en    (wr_en),
        .wr_idx   (wr_idx),
        .wr_data  (wr_data),
        .dbg_idx  (dbg_idx),
        .dbg_data (dbg_data)
    );

    cpu_ctrl_regs u_ctrl (
        .clk      (clk),
        .reset_n  (reset_n),
        .apb_req  (apb_req),
        .apb_rsp  (apb_rsp),
        .run      (run),
        .boot_pc  (boot_pc),
        .busy     (busy),
        .retire   (retire),
        .dbg_idx  (dbg_idx),
        .dbg_data (dbg_data)
    );

endmodule

`default_nettype wire

/* source/cpu_ctrl_regs.sv */
// APB slave with run control, boot PC, status, retired count and a register-file window
`timescale 1ns/1ns
`default_nettype none

module cpu_ctrl_regs (
    input  wire                    clk,
    input  wire                    reset_n,
    input  wire rv_pkg::apb_req_t  apb_req,
    output rv_pkg::apb_rsp_t       apb_rsp,
    output logic                   run,
    output rv_pkg::addr_t          boot_pc,
    input  wire                    busy,
    input  wire                    retire,
    output rv_pkg::reg_idx_t       dbg_idx,
    input  wire rv_pkg::xlen_t     dbg_data
);
    import rv_pkg::*;

    logic  access;
    logic  wr;
    logic  in_window;
    xlen_t retired;

    assign access    = apb_req.psel && apb_req.penable;
    assign wr        = access && apb_req.pwrite;
    // Window covers x0..x31, word aligned
    assign in_window = apb_req.paddr[11:7] == REG_XREG_BASE[11:7] && apb_req.paddr[1:0] == 2'b00;
    assign dbg_idx   = apb_req.paddr[6:2];

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            run     <= 1'b0;
            boot_pc <= '0;
            retired <= '0;
        end else begin
            if (wr && apb_req.paddr == REG_CTRL) begin
                run <= apb_req.pwdata[0];
            end
            if (wr && apb_req.paddr == REG_BOOT_PC) begin
                boot_pc <= apb_req.pwdata;
            end
            // Any write clears the count
            if (wr && apb_req.paddr == REG_RETIRED) begin
                retired <= '0;
            end else if (retire) begin
                retired <= retired + 32'd1;
            end
        end
    end

    always_comb begin
        apb_rsp.prdata  = '0;
        apb_rsp.pslverr = 1'b0;
        case (apb_req.paddr)
            REG_CTRL:    apb_rsp.prdata = {31'b0, run};
            REG_BOOT_PC: apb_rsp.prdata = boot_pc;
            REG_RETIRED: apb_rsp.prdata = retired;
            REG_STATUS: begin
                apb_rsp.prdata  = {31'b0, busy};
                apb_rsp.pslverr = wr;
            end
            default: begin
                if (in_window) begin
                    apb_rsp.prdata  = dbg_data;
                    apb_rsp.pslverr = wr;
                end else begin
                    apb_rsp.pslverr = access;
                end
            end
        endcase
    end

    // Access phase only right after a setup phase on the same address
    a_apb_setup: assert property (@(posedge clk) disable iff (!reset_n)
        apb_req.psel && apb_req.penable |->
            $past(apb_req.psel && !apb_req.penable) && $stable(apb_req.paddr));

endmodule

`default_nettype wire

/* source/cpu_pipeline.sv */
// Four-stage in-order pipeline: fetch handshake, decode, execute with forwarding, writeback
`timescale 1ns/1ns
`default_nettype none

module cpu_pipeline (
    input  wire                    clk,
    input  wire                    reset_n,
    input  wire                    run,
    input  wire rv_pkg::addr_t     boot_pc,
    output rv_pkg::imem_req_t      imem_req,
    input  wire rv_pkg::imem_rsp_t imem_rsp,
    output rv_pkg::reg_idx_t       rs1_idx,
    output rv_pkg::reg_idx_t       rs2_idx,
    input  wire rv_pkg::xlen_t     rs1_data,
    input  wire rv_pkg::xlen_t     rs2_data,
    output logic                   wr_en,
    output rv_pkg::reg_idx_t       wr_idx,
    output rv_pkg::xlen_t          wr_data,
    output logic                   busy,
    output logic                   retire
);
    import rv_pkg::*;

    typedef enum logic [1:0] {F_IDLE, F_REQ, F_DISCARD} fetch_state_e;

    fetch_state_e fstate;
    addr_t        pc;
    addr_t        hold_addr;
    logic         run_q;
    logic         start;
    logic         fetch_ok;
    logic         redirect;
    addr_t        target;

    logic         ifid_valid;
    addr_t        ifid_pc;
    instr_t       ifid_instr;
    decoded_t     id_dec;

    logic         idex_valid;
    addr_t        idex_pc;
    decoded_t     idex_dec;
    xlen_t        idex_op1;
    xlen_t        idex_op2;

    xlen_t        fwd_a;
    xlen_t        fwd_b;
    xlen_t        alu_b;
    xlen_t        alu_res;

    logic         exwb_valid;
    logic         exwb_reg_write;
    logic         exwb_is_branch;
    reg_idx_t     exwb_rd;
    xlen_t        exwb_res;

    logic         wb_valid;
    logic         wb_reg_write;
    logic         wb_is_branch;
    reg_idx_t     wb_rd;
    xlen_t        wb_res;

    // ------------------------------------------------------------
    // Fetch
    // ------------------------------------------------------------
    assign start    = run && !run_q && fstate == F_IDLE;
    assign fetch_ok = fstate == F_REQ && imem_rsp.ready && !redirect;

    always_comb begin
        imem_req.req  = fstate != F_IDLE;
        imem_req.addr = (fstate == F_DISCARD) ? hold_addr : pc;
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            fstate <= F_IDLE;
            pc     <= '0;
            run_q  <= 1'b0;
        end else begin
            run_q <= run;
            if (start) begin
                pc <= boot_pc;
            end else if (redirect) begin
                pc <= target;
            end else if (fetch_ok) begin
                pc <= pc + 32'd4;
            end
            case (fstate)
                F_IDLE: begin
                    if (start) begin
                        fstate <= F_REQ;
                    end
                end
                F_REQ: begin
                    if (imem_rsp.ready) begin
                        fstate <= run ? F_REQ : F_IDLE;
                    end else if (redirect) begin
                        fstate <= F_DISCARD;
                    end
                end
                default: begin
                    // Wrong-path word arrives and is dropped
                    if (imem_rsp.ready) begin
                        fstate <= run ? F_REQ : F_IDLE;
                    end
                end
            endcase
        end
    end

    // Address of the abandoned fetch, held until memory answers it
    always_ff @(posedge clk) begin
        if (fstate == F_REQ && redirect) begin
            hold_addr <= pc;
        end
    end

    // ------------------------------------------------------------
    // Stage valid bits and payload registers
    // ------------------------------------------------------------
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            ifid_valid <= 1'b0;
            idex_valid <= 1'b0;
            exwb_valid <= 1'b0;
            wb_valid   <= 1'b0;
        end else begin
            ifid_valid <= fetch_ok;
            // Illegal words drop out here as bubbles
            idex_valid <= ifid_valid && !redirect && (id_dec.reg_write || id_dec.is_branch);
            exwb_valid <= idex_valid;
            wb_valid   <= exwb_valid;
        end
    end

    always_ff @(posedge clk) begin
        ifid_instr     <= fetch_ok ? imem_rsp.rdata : NOP_INSTR;
        ifid_pc        <= pc;
        idex_pc        <= ifid_pc;
        idex_dec       <= id_dec;
        idex_op1       <= rs1_data;
        idex_op2       <= rs2_data;
        exwb_reg_write <= idex_dec.reg_write;
        exwb_is_branch <= idex_dec.is_branch;
        exwb_rd        <= idex_dec.rd;
        exwb_res       <= alu_res;
        wb_reg_write   <= exwb_reg_write;
        wb_is_branch   <= exwb_is_branch;
        wb_rd          <= exwb_rd;
        wb_res         <= exwb_res;
    end

    // ------------------------------------------------------------
    // Decode and execute
    // ------------------------------------------------------------
    instr_decoder u_decoder (
        .instr (ifid_instr),
        .dec   (id_dec)
    );

    assign rs1_idx = id_dec.rs1;
    assign rs2_idx = id_dec.rs2;

    // Youngest producer wins, x0 is never forwarded
    function automatic xlen_t forward(input reg_idx_t idx, input xlen_t rf_val);
        if (idx != '0 && exwb_valid && exwb_reg_write && exwb_rd == idx) begin
            return exwb_res;
        end
        if (idx != '0 && wb_valid && wb_reg_write && wb_rd == idx) begin
            return wb_res;
        end
        return rf_val;
    endfunction

    always_comb begin
        fwd_a    = forward(idex_dec.rs1, idex_op1);
        fwd_b    = forward(idex_dec.rs2, idex_op2);
        alu_b    = idex_dec.use_imm ? idex_dec.imm : fwd_b;
        target   = idex_pc + idex_dec.imm;
        redirect = idex_valid && idex_dec.is_branch && fwd_a == fwd_b;
    end

    alu u_alu (
        .op     (idex_dec.alu_op),
        .a      (fwd_a),
        .b      (alu_b),
        .result (alu_res)
    );

    // Writeback outputs
    assign wr_en   = wb_valid && wb_reg_write;
    assign wr_idx  = wb_rd;
    assign wr_data = wb_res;
    assign retire  = wb_valid;
    assign busy    = fstate != F_IDLE || ifid_valid || idex_valid || exwb_valid || wb_valid;

    // A pending fetch keeps its request and address until ready
    a_fetch_hold: assert property (@(posedge clk) disable iff (!reset_n)
        imem_req.req && !imem_rsp.ready |=> imem_req.req && $stable(imem_req.addr));

    // Only decoded writes and branches make it to retirement
    a_retire_kind: assert property (@(posedge clk) disable iff (!reset_n)
        retire |-> wr_en || wb_is_branch);

endmodule

`default_nettype wire

/* source/instr_decoder.sv */
// Decode stage logic: maps an instruction word onto the decoded-control struct
`timescale 1ns/1ns
`default_nettype none

module instr_decoder (
    input  wire rv_pkg::instr_t instr,
    output rv_pkg::decoded_t    dec
);
    import rv_pkg::*;

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    logic       alt;

    assign opcode = instr[6:0];
    assign funct3 = instr[14:12];
    assign funct7 = instr[31:25];
    // SUB and SRA variants
    assign alt    = funct7 == 7'b0100000;

    always_comb begin
        // Unknown encodings stay all zero, which is a bubble
        dec = '0;
        case (opcode)
            OPC_OP: begin
                if (funct7 == 7'b0 || (alt && (funct3 == 3'b000 || funct3 == 3'b101))) begin
                    dec.reg_write = 1'b1;
                    dec.rd        = instr[11:7];
                    dec.rs1       = instr[19:15];
                    dec.rs2       = instr[24:20];
                    case (funct3)
                        3'b000:  dec.alu_op = alt ? ALU_SUB : ALU_ADD;
                        3'b001:  dec.alu_op = ALU_SLL;
                        3'b010:  dec.alu_op = ALU_SLT;
                        3'b011:  dec.alu_op = ALU_SLTU;
                        3'b100:  dec.alu_op = ALU_XOR;
                        3'b101:  dec.alu_op = alt ? ALU_SRA : ALU_SRL;
                        3'b110:  dec.alu_op = ALU_OR;
                        default: dec.alu_op = ALU_AND;
                    endcase
                end
            end
            OPC_OP_IMM: begin
                // ADDI only
                if (funct3 == 3'b000) begin
                    dec.reg_write = 1'b1;
                    dec.use_imm   = 1'b1;
                    dec.alu_op    = ALU_ADD;
                    dec.rd        = instr[11:7];
                    dec.rs1       = instr[19:15];
                    dec.imm       = {{20{instr[31]}}, instr[31:20]};
                end
            end
            OPC_BRANCH: begin
                // BEQ only
                if (funct3 == 3'b000) begin
                    dec.is_branch = 1'b1;
                    dec.alu_op    = ALU_SUB;
                    dec.rs1       = instr[19:15];
                    dec.rs2       = instr[24:20];
                    dec.imm       = {{19{instr[31]}}, instr[31], instr[7],
                                     instr[30:25], instr[11:8], 1'b0};
                end
            end
            default: begin
            end
        endcase
    end

endmodule

`default_nettype wire

/* source/register_file.sv */
// Architectural register file with two decode read ports, a debug port and write-through
`timescale 1ns/1ns
`default_nettype none

module register_file (
    input  wire                  clk,
    input  wire                  reset_n,
    input  wire rv_pkg::reg_idx_t rs1_idx,
    input  wire rv_pkg::reg_idx_t rs2_idx,
    output rv_pkg::xlen_t        rs1_data,
    output rv_pkg::xlen_t        rs2_data,
    input  wire                  wr_en,
    input  wire rv_pkg::reg_idx_t wr_idx,
    input  wire rv_pkg::xlen_t   wr_data,
    input  wire rv_pkg::reg_idx_t dbg_idx,
    output rv_pkg::xlen_t        dbg_data
);
    import rv_pkg::*;

    xlen_t regs [NREGS];

    // x0 is never written, so it keeps its reset value of zero
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            for (int i = 0; i < NREGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en && wr_idx != '0) begin
            regs[wr_idx] <= wr_data;
        end
    end

    // A read of the register being written sees the new value
    function automatic xlen_t read_port(input reg_idx_t idx);
        if (wr_en && idx != '0 && idx == wr_idx) begin
            return wr_data;
        end
        return regs[idx];
    endfunction

    always_comb begin
        rs1_data = read_port(rs1_idx);
    end

    always_comb begin
        rs2_data = read_port(rs2_idx);
    end

    always_comb begin
        dbg_data = read_port(dbg_idx);
    end

endmodule

`default_nettype wire

/* source/alu.sv */
// Combinational 32-bit ALU used by the execute stage of the pipeline
`timescale 1ns/1ns
`default_nettype none

module alu (
    input  wire rv_pkg::alu_op_e op,
    input  wire rv_pkg::xlen_t   a,
    input  wire rv_pkg::xlen_t   b,
    output rv_pkg::xlen_t        result
);
    import rv_pkg::*;

    // Shift amount is the low five bits only
    logic [4:0] shamt;

    assign shamt = b[4:0];

    always_comb begin
        case (op)
            ALU_ADD:  result = a + b;
            ALU_SUB:  result = a - b;
            ALU_SLL:  result = a << shamt;
            ALU_SLT:  result = {31'b0, $signed(a) < $signed(b)};
            ALU_SLTU: result = {31'b0, a < b};
            ALU_XOR:  result = a ^ b;
            ALU_SRL:  result = a >> shamt;
            ALU_SRA:  result = $signed(a) >>> shamt;
            ALU_OR:   result = a | b;
            ALU_AND:  result = a & b;
            default:  result = '0;
        endcase
    end

endmodule

`default_nettype wire

/* source/rv_pkg.sv */
// Shared widths, opcodes, bus structs and APB register map; imported by every core module
`default_nettype none

package rv_pkg;

    localparam int XLEN  = 32;
    localparam int NREGS = 32;

    typedef logic [XLEN-1:0] xlen_t;
    typedef logic [XLEN-1:0] addr_t;
    typedef logic [31:0]     instr_t;
    typedef logic [4:0]      reg_idx_t;
    typedef logic [11:0]     apb_addr_t;

    // Major opcodes of the supported subset
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;

    // All-zero word is an illegal encoding, so it decodes to a bubble and never retires
    localparam instr_t NOP_INSTR = 32'h0000_0000;

    // APB register map
    localparam apb_addr_t REG_CTRL      = 12'h000;
    localparam apb_addr_t REG_BOOT_PC   = 12'h004;
    localparam apb_addr_t REG_STATUS    = 12'h008;
    localparam apb_addr_t REG_RETIRED   = 12'h00C;
    localparam apb_addr_t REG_XREG_BASE = 12'h100;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLL,
        ALU_SLT,
        ALU_SLTU,
        ALU_XOR,
        ALU_SRL,
        ALU_SRA,
        ALU_OR,
        ALU_AND
    } alu_op_e;

    typedef struct packed {
        alu_op_e  alu_op;
        logic     use_imm;
        logic     reg_write;
        logic     is_branch;
        reg_idx_t rd;
        reg_idx_t rs1;
        reg_idx_t rs2;
        xlen_t    imm;
    } decoded_t;

    typedef struct packed {
        logic  req;
        addr_t addr;
    } imem_req_t;

    typedef struct packed {
        logic   ready;
        instr_t rdata;
    } imem_rsp_t;

    typedef struct packed {
        logic      psel;
        logic      penable;
        logic      pwrite;
        apb_addr_t paddr;
        xlen_t     pwdata;
    } apb_req_t;

    typedef struct packed {
        xlen_t prdata;
        logic  pslverr;
    } apb_rsp_t;

endpackage

`default_nettype wire
